// ==== alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_XLEN        32
`define ALU_CODE_W      12
`define ALU_SHAMT_W     5
`define ALU_BIG_STEP    4

// major opcodes, low seven bits of the code
`define ALU_OPC_OP      7'b0110011
`define ALU_OPC_OP_IMM  7'b0010011
`define ALU_OPC_BRANCH  7'b1100011

// funct3, arithmetic and logic
`define ALU_F3_ADD      3'b000
`define ALU_F3_SLL      3'b001
`define ALU_F3_SLT      3'b010
`define ALU_F3_SLTU     3'b011
`define ALU_F3_XOR      3'b100
`define ALU_F3_SR       3'b101 // srl and sra share it
`define ALU_F3_OR       3'b110
`define ALU_F3_AND      3'b111

// funct3, branches
`define ALU_F3_BEQ      3'b000
`define ALU_F3_BNE      3'b001
`define ALU_F3_BLT      3'b100
`define ALU_F3_BGE      3'b101
`define ALU_F3_BLTU     3'b110
`define ALU_F3_BGEU     3'b111

`endif

// ==== alu_pkg.sv ====
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_or,
        op_slt,
        op_sltu,
        op_branch,
        op_shift,
        op_none
    } op_kind_e;

    typedef enum logic [1:0] {
        sh_srl,
        sh_sll,
        sh_sra
    } shift_kind_e;

    typedef struct packed {
        logic       alt_r;  // funct7 bit, sub and sra
        logic       alt_i;  // imm bit 10, srai
        logic [2:0] funct3;
        logic [6:0] opcode;
    } inst_fields_t;

    // raw view for the legality match, field view for the decode
    typedef union packed {
        logic [`ALU_CODE_W-1:0] raw;
        inst_fields_t           f;
    } inst_code_u;

endpackage

`default_nettype wire

// ==== alu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

interface alu_op_if;
    alu_pkg::op_kind_e    kind;
    alu_pkg::shift_kind_e shift_kind;
    logic                 writes_rd;
    logic                 legal;
    logic [2:0]           funct3; // branch condition select

    modport decoder (
        output kind,
        output shift_kind,
        output writes_rd,
        output legal,
        output funct3
    );

    modport consumer (
        input kind,
        input shift_kind,
        input writes_rd,
        input legal,
        input funct3
    );
endinterface

interface alu_shift_if;
    logic                 start;  // one-cycle load pulse
    logic [`ALU_XLEN-1:0] result;
    logic                 done;   // count at zero after a load

    modport ctrl (
        output start,
        input  result,
        input  done
    );

    modport unit (
        input  start,
        output result,
        output done
    );
endinterface

`default_nettype wire

// ==== alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_decoder (
    input  wire alu_pkg::inst_code_u    decinst,
    input  wire [`ALU_XLEN-1:0]         rs2,
    input  wire [`ALU_XLEN-1:0]         imm,
    output logic [`ALU_XLEN-1:0]        oper2,
    alu_op_if.decoder                   op
);

    logic legal_raw;
    logic use_imm;

    // exact match against every supported code
    always_comb begin
        case (decinst.raw)
            {2'b00, `ALU_F3_ADD, `ALU_OPC_OP}, {2'b00, `ALU_F3_ADD, `ALU_OPC_OP_IMM},
            {2'b10, `ALU_F3_ADD, `ALU_OPC_OP},
            {2'b00, `ALU_F3_AND, `ALU_OPC_OP}, {2'b00, `ALU_F3_AND, `ALU_OPC_OP_IMM},
            {2'b00, `ALU_F3_XOR, `ALU_OPC_OP}, {2'b00, `ALU_F3_XOR, `ALU_OPC_OP_IMM},
            {2'b00, `ALU_F3_OR, `ALU_OPC_OP}, {2'b00, `ALU_F3_OR, `ALU_OPC_OP_IMM},
            {2'b00, `ALU_F3_SLT, `ALU_OPC_OP}, {2'b00, `ALU_F3_SLT, `ALU_OPC_OP_IMM},
            {2'b00, `ALU_F3_SLTU, `ALU_OPC_OP}, {2'b00, `ALU_F3_SLTU, `ALU_OPC_OP_IMM},
            {2'b00, `ALU_F3_BEQ, `ALU_OPC_BRANCH}, {2'b00, `ALU_F3_BNE, `ALU_OPC_BRANCH},
            {2'b00, `ALU_F3_BLT, `ALU_OPC_BRANCH}, {2'b00, `ALU_F3_BGE, `ALU_OPC_BRANCH},
            {2'b00, `ALU_F3_BLTU, `ALU_OPC_BRANCH}, {2'b00, `ALU_F3_BGEU, `ALU_OPC_BRANCH},
            {2'b00, `ALU_F3_SLL, `ALU_OPC_OP}, {2'b00, `ALU_F3_SLL, `ALU_OPC_OP_IMM},
            {2'b00, `ALU_F3_SR, `ALU_OPC_OP}, {2'b00, `ALU_F3_SR, `ALU_OPC_OP_IMM},
            {2'b10, `ALU_F3_SR, `ALU_OPC_OP}, {2'b01, `ALU_F3_SR, `ALU_OPC_OP_IMM}:
                legal_raw = 1'b1;
            default:
                legal_raw = 1'b0;
        endcase
    end

    always_comb begin
        op.kind       = alu_pkg::op_none;
        op.shift_kind = alu_pkg::sh_srl;
        op.funct3     = decinst.f.funct3;
        use_imm       = decinst.f.opcode == `ALU_OPC_OP_IMM;
        if (legal_raw) begin
            if (decinst.f.opcode == `ALU_OPC_BRANCH) begin
                op.kind = alu_pkg::op_branch;
            end else begin
                case (decinst.f.funct3)
                    `ALU_F3_ADD:  op.kind = decinst.f.alt_r ? alu_pkg::op_sub : alu_pkg::op_add;
                    `ALU_F3_SLT:  op.kind = alu_pkg::op_slt;
                    `ALU_F3_SLTU: op.kind = alu_pkg::op_sltu;
                    `ALU_F3_XOR:  op.kind = alu_pkg::op_xor;
                    `ALU_F3_OR:   op.kind = alu_pkg::op_or;
                    `ALU_F3_AND:  op.kind = alu_pkg::op_and;
                    `ALU_F3_SLL: begin
                        op.kind       = alu_pkg::op_shift;
                        op.shift_kind = alu_pkg::sh_sll;
                    end
                    default: begin // srl, sra and their immediates
                        op.kind       = alu_pkg::op_shift;
                        op.shift_kind = (decinst.f.alt_r || decinst.f.alt_i) ?
                                        alu_pkg::sh_sra : alu_pkg::sh_srl;
                    end
                endcase
            end
        end
        op.legal     = legal_raw;
        op.writes_rd = legal_raw && (decinst.f.opcode != `ALU_OPC_BRANCH);
    end

    assign oper2 = use_imm ? imm : rs2;

endmodule

`default_nettype wire

// ==== alu_arith_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_arith_logic (
    input  wire [`ALU_XLEN-1:0]  rs1,
    input  wire [`ALU_XLEN-1:0]  oper2,
    alu_op_if.consumer           op,
    output logic [`ALU_XLEN-1:0] result,
    output logic                 carry
);

    logic [`ALU_XLEN:0] sum; // one extra bit for carry-out

    assign sum = {1'b0, rs1} + {1'b0, oper2};

    always_comb begin
        carry = 1'b0;
        case (op.kind)
            alu_pkg::op_add: begin
                result = sum[`ALU_XLEN-1:0];
                carry  = sum[`ALU_XLEN];
            end
            alu_pkg::op_sub: result = rs1 - oper2;
            alu_pkg::op_and: result = rs1 & oper2;
            alu_pkg::op_xor: result = rs1 ^ oper2;
            alu_pkg::op_or:  result = rs1 | oper2;
            default:         result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_compare (
    input  wire [`ALU_XLEN-1:0] rs1,
    input  wire [`ALU_XLEN-1:0] oper2,
    alu_op_if.consumer          op,
    output logic                cmp,
    output logic                slt_result
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = rs1 == oper2;
    assign lt_s = $signed(rs1) < $signed(oper2);
    assign lt_u = rs1 < oper2;

    always_comb begin
        cmp = 1'b0;
        if (op.kind == alu_pkg::op_branch) begin
            case (op.funct3)
                `ALU_F3_BEQ:  cmp = eq;
                `ALU_F3_BNE:  cmp = !eq;
                `ALU_F3_BLT:  cmp = lt_s;
                `ALU_F3_BGE:  cmp = !lt_s;
                `ALU_F3_BLTU: cmp = lt_u;
                `ALU_F3_BGEU: cmp = !lt_u;
                default:      cmp = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (op.kind)
            alu_pkg::op_slt:  slt_result = lt_s;
            alu_pkg::op_sltu: slt_result = lt_u;
            default:          slt_result = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_shifter (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`ALU_XLEN-1:0]        rs1,
    input  wire [`ALU_SHAMT_W-1:0]     amount,
    alu_op_if.consumer                 op,
    alu_shift_if.unit                  sh
);

    localparam logic [`ALU_SHAMT_W-1:0] big_step = `ALU_BIG_STEP;
    localparam logic [`ALU_SHAMT_W-1:0] one_step = 1;

    logic [`ALU_XLEN-1:0]    value;
    logic [`ALU_SHAMT_W-1:0] count;  // remaining shift amount
    logic [`ALU_SHAMT_W-1:0] step;
    logic                    loaded;

    assign step = (count >= big_step) ? big_step : one_step;

    always_ff @(posedge clk) begin
        if (sh.start) begin
            value <= rs1;
        end else if (count != '0) begin
            case (op.shift_kind)
                alu_pkg::sh_sll: value <= value << step;
                alu_pkg::sh_sra: value <= $signed(value) >>> step;
                default:         value <= value >> step;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            count  <= '0;
            loaded <= 1'b0;
        end else if (sh.start) begin
            count  <= amount;
            loaded <= 1'b1;
        end else if (count != '0) begin
            count <= count - step;
        end
    end

    assign sh.done   = loaded && (count == '0);
    assign sh.result = value;

    // only a new load may raise the count
    a_count_down: assert property (
        @(posedge clk) disable iff (!reset)
        !sh.start |=> (count <= $past(count))
    ) else $error("shifter: count rose without a start");

endmodule

`default_nettype wire

// ==== alu_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_result_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  en,
    alu_op_if.consumer           op,
    input  wire [`ALU_XLEN-1:0]  alu_result,
    input  wire                  alu_carry,
    input  wire                  cmp_in,
    input  wire                  slt_result,
    alu_shift_if.ctrl            sh,
    output logic [`ALU_XLEN-1:0] rd,
    output logic                 cmp,
    output logic                 carry,
    output logic                 is_rd,
    output logic                 is_inst
);

    logic                 started; // set at edge E
    logic                 is_shift;
    logic                 capture;
    logic [`ALU_XLEN-1:0] result_mux;
    logic [`ALU_XLEN-1:0] rd_q;

    assign is_shift = op.kind == alu_pkg::op_shift;
    assign sh.start = en && op.legal && is_shift && !started;
    assign capture  = en && op.legal && (is_shift ? (started && sh.done) : !started);

    always_comb begin
        case (op.kind)
            alu_pkg::op_slt, alu_pkg::op_sltu:
                result_mux = {{(`ALU_XLEN-1){1'b0}}, slt_result};
            alu_pkg::op_shift:
                result_mux = sh.result;
            default:
                result_mux = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            started <= 1'b0;
            is_inst <= 1'b0;
            is_rd   <= 1'b0;
            cmp     <= 1'b0;
            carry   <= 1'b0;
        end else if (!en) begin // abort or gap between instructions
            started <= 1'b0;
            is_inst <= 1'b0;
            is_rd   <= 1'b0;
        end else begin
            if (op.legal) begin
                started <= 1'b1;
            end
            if (capture) begin
                cmp     <= cmp_in;
                carry   <= alu_carry;
                is_inst <= 1'b1;
                is_rd   <= op.writes_rd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rd_q <= result_mux;
        end
    end

    assign rd = is_rd ? rd_q : '0;

    a_rd_needs_inst: assert property (
        @(posedge clk) disable iff (!reset)
        is_rd |-> is_inst
    ) else $error("result stage: is_rd without is_inst");

endmodule

`default_nettype wire

// ==== alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   en,
    input  wire [`ALU_CODE_W-1:0] decinst,
    input  wire [`ALU_XLEN-1:0]   rs1,
    input  wire [`ALU_XLEN-1:0]   rs2,
    input  wire [`ALU_XLEN-1:0]   imm,
    output wire [`ALU_XLEN-1:0]   rd,
    output wire                   cmp,
    output wire                   carry,
    output wire                   is_rd,
    output wire                   is_inst
);

    wire [`ALU_XLEN-1:0] oper2;
    wire [`ALU_XLEN-1:0] alu_result;
    wire                 alu_carry;
    wire                 cmp_w;
    wire                 slt_result;

    alu_op_if    op_if ();
    alu_shift_if sh_if ();

    alu_decoder alu_decoder_i (
        .decinst (alu_pkg::inst_code_u'(decinst)),
        .rs2     (rs2),
        .imm     (imm),
        .oper2   (oper2),
        .op      (op_if)
    );

    alu_arith_logic alu_arith_logic_i (
        .rs1    (rs1),
        .oper2  (oper2),
        .op     (op_if),
        .result (alu_result),
        .carry  (alu_carry)
    );

    alu_compare alu_compare_i (
        .rs1        (rs1),
        .oper2      (oper2),
        .op         (op_if),
        .cmp        (cmp_w),
        .slt_result (slt_result)
    );

    alu_shifter alu_shifter_i (
        .clk    (clk),
        .reset  (reset),
        .rs1    (rs1),
        .amount (oper2[`ALU_SHAMT_W-1:0]), // low bits of the second operand
        .op     (op_if),
        .sh     (sh_if)
    );

    alu_result_stage alu_result_stage_i (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .op         (op_if),
        .alu_result (alu_result),
        .alu_carry  (alu_carry),
        .cmp_in     (cmp_w),
        .slt_result (slt_result),
        .sh         (sh_if),
        .rd         (rd),
        .cmp        (cmp),
        .carry      (carry),
        .is_rd      (is_rd),
        .is_inst    (is_inst)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module tb_alu_top;

    localparam logic [31:0] seed = 32'hf486_e42b;
    localparam int n_rand = 8;
    localparam int n_br_rand = 4;
    localparam int n_sh_rand = 3;
    localparam int n_instr = 13 * n_rand + 4 + 6 * (n_br_rand + 1) + 6 * (6 + n_sh_rand) + 5 + 3;
    localparam int timeout_cycles = n_instr * 16 + 100;
    localparam logic [7:0] max_wait = 8'd16;
    localparam logic [4:0] shift_amounts [6] = '{5'd0, 5'd1, 5'd3, 5'd4, 5'd5, 5'd31};

    typedef struct packed {
        logic                 legal;
        logic                 is_rd;
        logic                 cmp;
        logic                 carry;
        logic [7:0]           lat; // edges from E to is_inst, E counted
        logic [`ALU_XLEN-1:0] rd;
    } exp_t;

    typedef struct packed {
        logic                 exp_inst;
        logic                 exp_is_rd;
        logic                 exp_cmp;
        logic                 exp_carry;
        logic                 check_cc;
        logic [7:0]           exp_lat; // zero skips the latency check
        logic [`ALU_XLEN-1:0] exp_rd;
        logic                 act_inst;
        logic                 act_is_rd;
        logic                 act_cmp;
        logic                 act_carry;
        logic [7:0]           act_lat;
        logic [`ALU_XLEN-1:0] act_rd;
    } rec_t;

    logic                   clk;
    logic                   reset;
    logic                   en;
    logic [`ALU_CODE_W-1:0] decinst;
    logic [`ALU_XLEN-1:0]   rs1;
    logic [`ALU_XLEN-1:0]   rs2;
    logic [`ALU_XLEN-1:0]   imm;
    wire  [`ALU_XLEN-1:0]   rd;
    wire                    cmp;
    wire                    carry;
    wire                    is_rd;
    wire                    is_inst;

    logic [31:0] rng_state;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count;
    rec_t        rec_q[$];
    string       name_q[$];

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    alu_top alu_top_i (
        .clk     (clk),
        .reset   (reset),
        .en      (en),
        .decinst (decinst),
        .rs1     (rs1),
        .rs2     (rs2),
        .imm     (imm),
        .rd      (rd),
        .cmp     (cmp),
        .carry   (carry),
        .is_rd   (is_rd),
        .is_inst (is_inst)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [`ALU_CODE_W-1:0] make_code(input logic [1:0] alt,
                                                         input logic [2:0] f3,
                                                         input logic [6:0] opc);
        return {alt, f3, opc};
    endfunction

    // expected outputs straight from the RV32I rules
    function automatic exp_t ref_exec(input logic [`ALU_CODE_W-1:0] code,
                                      input logic [`ALU_XLEN-1:0] a,
                                      input logic [`ALU_XLEN-1:0] r2,
                                      input logic [`ALU_XLEN-1:0] im);
        alu_pkg::inst_code_u  c;
        exp_t                 e;
        logic [`ALU_XLEN-1:0] b;
        logic [`ALU_XLEN-1:0] sum;
        logic                 imm_form;
        logic                 lt_s;
        logic                 lt_u;
        int                   n;
        c.raw = code;
        e = '0;
        e.lat = 8'd1;
        imm_form = c.f.opcode == `ALU_OPC_OP_IMM;
        b = imm_form ? im : r2;
        n = int'(b[`ALU_SHAMT_W-1:0]);
        sum = a + b;
        lt_s = {~a[`ALU_XLEN-1], a[`ALU_XLEN-2:0]} < {~b[`ALU_XLEN-1], b[`ALU_XLEN-2:0]};
        lt_u = a < b;
        if (c.f.opcode == `ALU_OPC_BRANCH) begin
            e.legal = code[11:10] == 2'b00;
            case (c.f.funct3)
                `ALU_F3_BEQ:  e.cmp = a == b;
                `ALU_F3_BNE:  e.cmp = a != b;
                `ALU_F3_BLT:  e.cmp = lt_s;
                `ALU_F3_BGE:  e.cmp = !lt_s;
                `ALU_F3_BLTU: e.cmp = lt_u;
                `ALU_F3_BGEU: e.cmp = !lt_u;
                default:      e.legal = 1'b0;
            endcase
        end else if (imm_form || c.f.opcode == `ALU_OPC_OP) begin
            e.legal = code[11:10] == 2'b00;
            case (c.f.funct3)
                `ALU_F3_ADD: begin
                    if (!imm_form && code[11:10] == 2'b10) begin // sub
                        e.legal = 1'b1;
                        e.rd = a - b;
                    end else begin
                        e.rd = sum;
                        e.carry = sum < a; // sum wrapped past the top
                    end
                end
                `ALU_F3_SLT:  e.rd = {{(`ALU_XLEN-1){1'b0}}, lt_s};
                `ALU_F3_SLTU: e.rd = {{(`ALU_XLEN-1){1'b0}}, lt_u};
                `ALU_F3_XOR:  e.rd = a ^ b;
                `ALU_F3_OR:   e.rd = a | b;
                `ALU_F3_AND:  e.rd = a & b;
                `ALU_F3_SLL: begin
                    e.rd = a << n;
                    e.lat = 8'(n / `ALU_BIG_STEP + n % `ALU_BIG_STEP + 2);
                end
                default: begin
                    if (code[11:10] == (imm_form ? 2'b01 : 2'b10)) begin
                        e.legal = 1'b1;
                        e.rd = $signed(a) >>> n;
                    end else begin
                        e.rd = a >> n;
                    end
                    e.lat = 8'(n / `ALU_BIG_STEP + n % `ALU_BIG_STEP + 2);
                end
            endcase
            e.is_rd = e.legal;
        end
        if (!e.is_rd) begin
            e.rd = '0; // rd reads zero without is_rd
        end
        return e;
    endfunction

    function automatic rec_t capture_outputs(input rec_t r);
        rec_t s;
        s = r;
        s.act_inst = is_inst;
        s.act_is_rd = is_rd;
        s.act_rd = rd;
        s.act_cmp = cmp;
        s.act_carry = carry;
        return s;
    endfunction

    // expects all flags and rd low
    task automatic record_idle(input string name, input logic check_cc);
        rec_t r;
        r = '0;
        r.check_cc = check_cc;
        r = capture_outputs(r);
        rec_q.push_back(r);
        name_q.push_back(name);
    endtask

    // entered and left 1 ns after a rising edge, en low on the last edge
    task automatic run_instr(input string name, input logic [`ALU_CODE_W-1:0] code,
                             input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] r2,
                             input logic [`ALU_XLEN-1:0] im);
        exp_t       e;
        rec_t       r;
        logic [7:0] edges;
        e = ref_exec(code, a, r2, im);
        r = '0;
        decinst = code;
        rs1 = a;
        rs2 = r2;
        imm = im;
        en = 1'b1;
        if (e.legal) begin
            @(posedge clk);
            #1;
            edges = 8'd1;
            while (!is_inst && edges < max_wait) begin
                @(posedge clk);
                #1;
                edges = edges + 8'd1;
            end
            r = capture_outputs(r);
            r.act_lat = edges;
            r.exp_inst = 1'b1;
            r.exp_is_rd = e.is_rd;
            r.exp_cmp = e.cmp;
            r.exp_carry = e.carry;
            r.check_cc = 1'b1;
            r.exp_lat = e.lat;
            r.exp_rd = e.rd;
        end else begin
            repeat (4) begin
                @(posedge clk);
                #1;
                r.act_inst = r.act_inst | is_inst;
                r.act_is_rd = r.act_is_rd | is_rd;
                r.act_rd = r.act_rd | rd;
            end
        end
        rec_q.push_back(r);
        name_q.push_back(name);
        en = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic run_random(input string name, input logic [`ALU_CODE_W-1:0] code);
        logic [`ALU_XLEN-1:0] a;
        logic [`ALU_XLEN-1:0] b;
        logic [`ALU_XLEN-1:0] c;
        for (int i = 0; i < n_rand; i++) begin
            a = next_rand();
            b = next_rand();
            c = next_rand();
            run_instr(name, code, a, b, c);
        end
    endtask

    task automatic run_branch(input string name, input logic [`ALU_CODE_W-1:0] code);
        logic [`ALU_XLEN-1:0] a;
        logic [`ALU_XLEN-1:0] b;
        for (int i = 0; i <= n_br_rand; i++) begin
            a = next_rand();
            b = (i == n_br_rand) ? a : next_rand(); // last pass on equal operands
            run_instr(name, code, a, b, next_rand());
        end
    endtask

    task automatic run_shift(input string name, input logic [`ALU_CODE_W-1:0] code,
                             input logic imm_form, input logic neg_rs1);
        logic [`ALU_XLEN-1:0]    a;
        logic [`ALU_XLEN-1:0]    upper;
        logic [`ALU_XLEN-1:0]    other;
        logic [`ALU_XLEN-1:0]    opnd;
        logic [`ALU_SHAMT_W-1:0] amt;
        for (int i = 0; i < 6 + n_sh_rand; i++) begin
            upper = next_rand();
            amt = (i < 6) ? shift_amounts[i] : upper[`ALU_SHAMT_W-1:0];
            a = next_rand();
            if (neg_rs1 && i < 6) begin
                a[`ALU_XLEN-1] = 1'b1;
            end
            opnd = {upper[`ALU_XLEN-1:`ALU_SHAMT_W], amt}; // upper bits must not matter
            other = next_rand();
            if (imm_form) begin
                run_instr(name, code, a, other, opnd);
            end else begin
                run_instr(name, code, a, opnd, other);
            end
        end
    endtask

    task automatic run_abort(input string name, input logic [`ALU_CODE_W-1:0] code,
                             input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
        decinst = code;
        rs1 = a;
        rs2 = b;
        imm = '0;
        en = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        en = 1'b0;
        @(posedge clk);
        #1;
        record_idle(name, 1'b0); // cmp and carry hold older values
    endtask

    always @(negedge clk) begin : compare
        rec_t  r;
        string nm;
        while (rec_q.size() > 0) begin
            r = rec_q.pop_front();
            nm = name_q.pop_front();
            check_count++;
            if (r.act_inst !== r.exp_inst) begin
                error_count++;
                $display("[ERROR] %s is_inst expected %0b actual %0b", nm, r.exp_inst, r.act_inst);
            end
            if (r.act_is_rd !== r.exp_is_rd) begin
                error_count++;
                $display("[ERROR] %s is_rd expected %0b actual %0b", nm, r.exp_is_rd, r.act_is_rd);
            end
            if (r.act_rd !== r.exp_rd) begin
                error_count++;
                $display("[ERROR] %s rd expected %h actual %h", nm, r.exp_rd, r.act_rd);
            end
            if (r.check_cc && r.act_cmp !== r.exp_cmp) begin
                error_count++;
                $display("[ERROR] %s cmp expected %0b actual %0b", nm, r.exp_cmp, r.act_cmp);
            end
            if (r.check_cc && r.act_carry !== r.exp_carry) begin
                error_count++;
                $display("[ERROR] %s carry expected %0b actual %0b", nm, r.exp_carry, r.act_carry);
            end
            if (r.exp_lat != 8'd0 && r.act_lat !== r.exp_lat) begin
                error_count++;
                $display("[ERROR] %s latency expected %0d actual %0d", nm, r.exp_lat, r.act_lat);
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles, %0d errors so far",
                 timeout_cycles, error_count);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        en = 1'b0;
        decinst = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        rng_state = seed;
        wait (reset === 1'b1);
        @(posedge clk);
        #1;
        record_idle("after reset", 1'b1);
        run_random("add", make_code(2'b00, `ALU_F3_ADD, `ALU_OPC_OP));
        run_random("sub", make_code(2'b10, `ALU_F3_ADD, `ALU_OPC_OP));
        run_random("and", make_code(2'b00, `ALU_F3_AND, `ALU_OPC_OP));
        run_random("xor", make_code(2'b00, `ALU_F3_XOR, `ALU_OPC_OP));
        run_random("or", make_code(2'b00, `ALU_F3_OR, `ALU_OPC_OP));
        run_random("slt", make_code(2'b00, `ALU_F3_SLT, `ALU_OPC_OP));
        run_random("sltu", make_code(2'b00, `ALU_F3_SLTU, `ALU_OPC_OP));
        run_random("addi", make_code(2'b00, `ALU_F3_ADD, `ALU_OPC_OP_IMM));
        run_random("andi", make_code(2'b00, `ALU_F3_AND, `ALU_OPC_OP_IMM));
        run_random("xori", make_code(2'b00, `ALU_F3_XOR, `ALU_OPC_OP_IMM));
        run_random("ori", make_code(2'b00, `ALU_F3_OR, `ALU_OPC_OP_IMM));
        run_random("slti", make_code(2'b00, `ALU_F3_SLT, `ALU_OPC_OP_IMM));
        run_random("sltiu", make_code(2'b00, `ALU_F3_SLTU, `ALU_OPC_OP_IMM));
        run_instr("add carry", make_code(2'b00, `ALU_F3_ADD, `ALU_OPC_OP),
                  32'hffff_ffff, 32'h0000_0001, 32'h0);
        run_instr("addi carry", make_code(2'b00, `ALU_F3_ADD, `ALU_OPC_OP_IMM),
                  32'h8000_0000, 32'h0, 32'h8000_0000);
        run_instr("slt negative", make_code(2'b00, `ALU_F3_SLT, `ALU_OPC_OP),
                  32'h8000_0000, 32'h1, 32'h0);
        run_instr("sltu negative", make_code(2'b00, `ALU_F3_SLTU, `ALU_OPC_OP),
                  32'h8000_0000, 32'h1, 32'h0);
        run_branch("beq", make_code(2'b00, `ALU_F3_BEQ, `ALU_OPC_BRANCH));
        run_branch("bne", make_code(2'b00, `ALU_F3_BNE, `ALU_OPC_BRANCH));
        run_branch("blt", make_code(2'b00, `ALU_F3_BLT, `ALU_OPC_BRANCH));
        run_branch("bge", make_code(2'b00, `ALU_F3_BGE, `ALU_OPC_BRANCH));
        run_branch("bltu", make_code(2'b00, `ALU_F3_BLTU, `ALU_OPC_BRANCH));
        run_branch("bgeu", make_code(2'b00, `ALU_F3_BGEU, `ALU_OPC_BRANCH));
        run_shift("sll", make_code(2'b00, `ALU_F3_SLL, `ALU_OPC_OP), 1'b0, 1'b0);
        run_shift("srl", make_code(2'b00, `ALU_F3_SR, `ALU_OPC_OP), 1'b0, 1'b0);
        run_shift("sra", make_code(2'b10, `ALU_F3_SR, `ALU_OPC_OP), 1'b0, 1'b1);
        run_shift("slli", make_code(2'b00, `ALU_F3_SLL, `ALU_OPC_OP_IMM), 1'b1, 1'b0);
        run_shift("srli", make_code(2'b00, `ALU_F3_SR, `ALU_OPC_OP_IMM), 1'b1, 1'b0);
        run_shift("srai", make_code(2'b01, `ALU_F3_SR, `ALU_OPC_OP_IMM), 1'b1, 1'b1);
        run_instr("illegal subi", make_code(2'b10, `ALU_F3_ADD, `ALU_OPC_OP_IMM), 1, 2, 3);
        run_instr("illegal alt_i on R", make_code(2'b01, `ALU_F3_SR, `ALU_OPC_OP), 4, 5, 6);
        run_instr("illegal branch f3", make_code(2'b00, 3'b010, `ALU_OPC_BRANCH), 7, 7, 0);
        run_instr("illegal opcode", make_code(2'b00, `ALU_F3_ADD, 7'b0000011), 8, 9, 10);
        run_instr("illegal alt 11", make_code(2'b11, `ALU_F3_SR, `ALU_OPC_OP), 11, 12, 13);
        run_abort("aborted sra", make_code(2'b10, `ALU_F3_SR, `ALU_OPC_OP),
                  32'h9234_5678, 32'd31);
        run_instr("sll after abort", make_code(2'b00, `ALU_F3_SLL, `ALU_OPC_OP),
                  32'h0000_0001, 32'd31, 32'h0);
        run_instr("add after abort", make_code(2'b00, `ALU_F3_ADD, `ALU_OPC_OP),
                  32'h1234_5678, 32'h0101_0101, 32'h0);
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_top.f ====
+incdir+.
alu_pkg.sv
alu_ifs.sv
alu_decoder.sv
alu_arith_logic.sv
alu_compare.sv
alu_shifter.sv
alu_result_stage.sv
alu_top.sv
tb_clock_gen.sv
tb_alu_top.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_alu_top \
    -f alu_top.f -Mdir obj_dir -o tb_alu_top > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_alu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
